// ==== Makefile ====
# Verilator build and run for the Ethernet aggregator testbench

VERILATOR ?= verilator
TOP       ?= tb_eth_aggregator
FILELIST  ?= eth_aggregator.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All tests passed
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== eth_aggregator.f ====
source/ethagg_pkg.sv
source/rx_frame_fifo.sv
source/frame_arbiter.sv
source/uplink_credit_tx.sv
source/eth_aggregator.sv
tb/agg_checker.sv
tb/tb_eth_aggregator.sv

// ==== source/eth_aggregator.sv ====
// top level of the multi-port Ethernet receive aggregator
// one frame FIFO per MAC port, a round-robin merge and the credit uplink
`default_nettype none

module eth_aggregator #(
    parameter int ETHCOUNT       = 4,
    parameter int FIFO_DEPTH     = 32,
    parameter int UPLINK_CREDITS = 4
) (
    input  wire                                              clk20_g,
    input  wire                                              rst_n_i,
    input  wire [ETHCOUNT-1:0]                               mac_valid_i,
    input  wire ethagg_pkg::eth_beat_t                       mac_beat_i [ETHCOUNT],
    input  wire ethagg_pkg::port_status_t                    mac_status_i [ETHCOUNT],
    input  wire                                              up_credit_i,
    output logic                                             up_valid_o,
    output ethagg_pkg::up_beat_t                             up_beat_o,
    output logic [ETHCOUNT-1:0][ethagg_pkg::DROP_CNT_W-1:0] drop_count_o
);
    import ethagg_pkg::*;

    // FIFO heads toward the arbiter
    logic [ETHCOUNT-1:0] has_frame;
    eth_beat_t           head [ETHCOUNT];
    logic [ETHCOUNT-1:0] pop;

    // merged stream toward the uplink register
    logic     arb_valid;
    up_beat_t arb_beat;
    logic     arb_ready;

    // ------------------------------------------------------------------------
    // per-port receive stores
    // ------------------------------------------------------------------------
    for (genvar g = 0; g < ETHCOUNT; g++) begin : g_port
        rx_frame_fifo #(
            .FIFO_DEPTH (FIFO_DEPTH)
        ) u_fifo (
            .clk20_g      (clk20_g),
            .rst_n_i      (rst_n_i),
            .valid_i      (mac_valid_i[g]),
            .beat_i       (mac_beat_i[g]),
            .status_i     (mac_status_i[g]),
            .pop_i        (pop[g]),
            .has_frame_o  (has_frame[g]),
            .head_o       (head[g]),
            .drop_count_o (drop_count_o[g])
        );
    end

    frame_arbiter #(
        .ETHCOUNT (ETHCOUNT)
    ) u_arb (
        .clk20_g     (clk20_g),
        .rst_n_i     (rst_n_i),
        .has_frame_i (has_frame),
        .head_i      (head),
        .ready_i     (arb_ready),
        .pop_o       (pop),
        .valid_o     (arb_valid),
        .beat_o      (arb_beat)
    );

    uplink_credit_tx #(
        .UPLINK_CREDITS (UPLINK_CREDITS)
    ) u_tx (
        .clk20_g     (clk20_g),
        .rst_n_i     (rst_n_i),
        .valid_i     (arb_valid),
        .beat_i      (arb_beat),
        .up_credit_i (up_credit_i),
        .ready_o     (arb_ready),
        .up_valid_o  (up_valid_o),
        .up_beat_o   (up_beat_o)
    );

endmodule

`default_nettype wire

// ==== source/ethagg_pkg.sv ====
// shared types and constants for the Ethernet frame aggregator
// modules import this package inside their bodies; ports use scoped names
`default_nettype none

package ethagg_pkg;

    // ------------------------------------------------------------------------
    // sizes
    // ------------------------------------------------------------------------
    // upper bound on MAC ports
    localparam int MAX_PORTS  = 4;
    // port index width on the uplink tag
    localparam int PORT_W     = 2;
    localparam int BYTE_W     = 8;
    // saturating drop counter per port
    localparam int DROP_CNT_W = 8;

    // speed code reported by the MAC for gigabit
    localparam logic [1:0] SPEED_1G = 2'b10;

    // ------------------------------------------------------------------------
    // beats and status
    // ------------------------------------------------------------------------
    // one MAC receive beat, bad is the MAC frame error flag
    typedef struct packed {
        logic [BYTE_W-1:0] data;
        logic              last;
        logic              bad;
    } eth_beat_t;

    // MAC status nibble, link in bit 0 and speed above it
    typedef struct packed {
        logic       spare;
        logic [1:0] speed;
        logic       link;
    } port_status_t;

    // tagged uplink beat
    typedef struct packed {
        logic [PORT_W-1:0] port_idx;
        logic [BYTE_W-1:0] data;
        logic              last;
    } up_beat_t;

    // receive path only runs with link up at 1 Gb/s
    function automatic logic link_qualified(input port_status_t st);
        return st.link && (st.speed == SPEED_1G);
    endfunction

endpackage

`default_nettype wire

// ==== source/frame_arbiter.sv ====
// round-robin merge of the port FIFOs with one whole frame per grant
// beats are tagged with their port index on the way out
`default_nettype none

module frame_arbiter #(
    parameter int ETHCOUNT = 4
) (
    input  wire                         clk20_g,
    input  wire                         rst_n_i,
    input  wire [ETHCOUNT-1:0]          has_frame_i,
    input  wire ethagg_pkg::eth_beat_t  head_i [ETHCOUNT],
    input  wire                         ready_i,
    output logic [ETHCOUNT-1:0]         pop_o,
    output logic                        valid_o,
    output ethagg_pkg::up_beat_t        beat_o
);
    import ethagg_pkg::*;

    if (ETHCOUNT < 1 || ETHCOUNT > MAX_PORTS) begin : g_count_check
        $error("ETHCOUNT out of range");
    end

    logic [PORT_W-1:0] grant_q;
    // search starts just after the previous winner
    logic [PORT_W-1:0] last_q;
    logic              busy_q;

    logic [PORT_W-1:0] sel;
    logic              found;
    logic              xfer;

    // ------------------------------------------------------------------------
    // next winner search
    // ------------------------------------------------------------------------
    always_comb begin
        int idx;
        found = 1'b0;
        sel   = last_q;
        for (int i = 1; i <= ETHCOUNT; i++) begin
            idx = (int'(last_q) + i) % ETHCOUNT;
            if (!found && has_frame_i[idx]) begin
                found = 1'b1;
                sel   = PORT_W'(idx);
            end
        end
    end

    // granted port has its frame committed, so has_frame holds until its last pop
    assign valid_o         = busy_q && has_frame_i[grant_q];
    assign beat_o.port_idx = grant_q;
    assign beat_o.data     = head_i[grant_q].data;
    assign beat_o.last     = head_i[grant_q].last;
    assign xfer            = valid_o && ready_i;

    always_comb begin
        pop_o          = '0;
        pop_o[grant_q] = xfer;
    end

    always_ff @(posedge clk20_g or negedge rst_n_i) begin
        if (!rst_n_i) begin
            grant_q <= '0;
            // port 0 wins first
            last_q  <= PORT_W'(ETHCOUNT - 1);
            busy_q  <= 1'b0;
        end else if (!busy_q) begin
            if (found) begin
                grant_q <= sel;
                busy_q  <= 1'b1;
            end
        end else if (xfer && beat_o.last) begin
            // release after the last beat of the frame
            busy_q <= 1'b0;
            last_q <= grant_q;
        end
    end

    // granted frame stays stored until its last beat has left
    a_grant_held : assert property (
        @(posedge clk20_g) disable iff (!rst_n_i) busy_q |-> has_frame_i[grant_q]
    ) else $error("granted port lost its frame mid grant");

endmodule

`default_nettype wire

// ==== source/rx_frame_fifo.sv ====
// per-port frame store between one MAC receive stream and the arbiter
// only whole good frames become visible; dropped frames are rewound and counted
`default_nettype none

module rx_frame_fifo #(
    parameter int FIFO_DEPTH = 32
) (
    input  wire                               clk20_g,
    input  wire                               rst_n_i,
    input  wire                               valid_i,
    input  wire ethagg_pkg::eth_beat_t        beat_i,
    input  wire ethagg_pkg::port_status_t     status_i,
    input  wire                               pop_i,
    output logic                              has_frame_o,
    output ethagg_pkg::eth_beat_t             head_o,
    output logic [ethagg_pkg::DROP_CNT_W-1:0] drop_count_o
);
    import ethagg_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH);
    localparam logic [AW:0] DEPTH_V = (AW+1)'(FIFO_DEPTH);

    // frame byte store
    eth_beat_t mem [FIFO_DEPTH];

    // pointers carry one extra wrap bit
    logic [AW:0] wr_ptr;
    logic [AW:0] commit_ptr;
    logic [AW:0] rd_ptr;
    // committed frames still stored
    logic [AW:0] frames_q;
    // room seen when the current frame began
    logic [AW:0] room_q;
    logic        in_frame_q;
    // rest of current frame is thrown away
    logic        discard_q;

    logic        qual;
    logic [AW:0] free_now;
    logic [AW:0] room;
    logic [AW:0] frame_len;
    logic        fits;
    logic        drop_now;
    logic        wr_en;
    logic        commit;
    logic        pop_last;

    // ------------------------------------------------------------------------
    // drop decision
    // ------------------------------------------------------------------------
    always_comb begin
        qual      = link_qualified(status_i);
        // bytes of the current frame are not yet in the committed count
        free_now  = DEPTH_V - (commit_ptr - rd_ptr);
        room      = in_frame_q ? room_q : free_now;
        frame_len = wr_ptr - commit_ptr;
        fits      = frame_len < room;
        // link loss mid frame kills it even with no beat present
        drop_now  = !discard_q &&
                    ((valid_i && (!qual || beat_i.bad || !fits)) || (in_frame_q && !qual));
        wr_en     = valid_i && !discard_q && !drop_now;
        commit    = wr_en && beat_i.last;
        pop_last  = pop_i && head_o.last;
    end

    // write side
    always_ff @(posedge clk20_g) begin
        if (wr_en) begin
            mem[wr_ptr[AW-1:0]] <= beat_i;
        end
    end

    always_ff @(posedge clk20_g or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr     <= '0;
            commit_ptr <= '0;
            room_q     <= '0;
            in_frame_q <= 1'b0;
            discard_q  <= 1'b0;
        end else begin
            if (drop_now) begin
                // rewind to the last good frame boundary
                wr_ptr <= commit_ptr;
            end else if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (commit) begin
                commit_ptr <= wr_ptr + 1'b1;
            end
            // latch room on the first beat of each frame
            if (valid_i && !in_frame_q) begin
                room_q <= free_now;
            end
            if (valid_i) begin
                in_frame_q <= !beat_i.last;
            end
            // dropped on its own last beat needs no discard phase
            if (valid_i && beat_i.last) begin
                discard_q <= 1'b0;
            end else if (drop_now) begin
                discard_q <= 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // read side and counters
    // ------------------------------------------------------------------------
    always_ff @(posedge clk20_g or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_ptr       <= '0;
            frames_q     <= '0;
            drop_count_o <= '0;
        end else begin
            if (pop_i) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({commit, pop_last})
                2'b10:   frames_q <= frames_q + 1'b1;
                2'b01:   frames_q <= frames_q - 1'b1;
                default: frames_q <= frames_q;
            endcase
            // saturates at all ones
            if (drop_now && (drop_count_o != '1)) begin
                drop_count_o <= drop_count_o + 1'b1;
            end
        end
    end

    assign has_frame_o = (frames_q != '0);
    assign head_o      = mem[rd_ptr[AW-1:0]];

    // arbiter must only pull from a port holding a complete frame
    a_pop_needs_frame : assert property (
        @(posedge clk20_g) disable iff (!rst_n_i) pop_i |-> has_frame_o
    ) else $error("pop without a stored frame");

endmodule

`default_nettype wire

// ==== source/uplink_credit_tx.sv ====
// output register toward the uplink with credit based flow control
// the uplink starts with UPLINK_CREDITS free slots and pulses a credit per freed slot
`default_nettype none

module uplink_credit_tx #(
    parameter int UPLINK_CREDITS = 4
) (
    input  wire                        clk20_g,
    input  wire                        rst_n_i,
    input  wire                        valid_i,
    input  wire ethagg_pkg::up_beat_t  beat_i,
    input  wire                        up_credit_i,
    output logic                       ready_o,
    output logic                       up_valid_o,
    output ethagg_pkg::up_beat_t       up_beat_o
);
    import ethagg_pkg::*;

    localparam int CW = $clog2(UPLINK_CREDITS + 1);

    // slots free at the far end
    logic [CW-1:0] credit_q;
    logic          take;

    assign ready_o = (credit_q != '0);
    assign take    = valid_i && ready_o;

    // ------------------------------------------------------------------------
    // credit counter
    // ------------------------------------------------------------------------
    // a beat is charged when it enters the output register
    always_ff @(posedge clk20_g or negedge rst_n_i) begin
        if (!rst_n_i) begin
            credit_q <= CW'(UPLINK_CREDITS);
        end else begin
            case ({take, up_credit_i})
                2'b10:   credit_q <= credit_q - 1'b1;
                2'b01:   credit_q <= credit_q + 1'b1;
                default: credit_q <= credit_q;
            endcase
        end
    end

    // output register, one cycle from accept to uplink
    always_ff @(posedge clk20_g or negedge rst_n_i) begin
        if (!rst_n_i) begin
            up_valid_o <= 1'b0;
        end else begin
            up_valid_o <= take;
        end
    end

    always_ff @(posedge clk20_g) begin
        if (take) begin
            up_beat_o <= beat_i;
        end
    end

    // uplink must never return more credits than beats it received
    a_credit_bound : assert property (
        @(posedge clk20_g) disable iff (!rst_n_i) credit_q <= CW'(UPLINK_CREDITS)
    ) else $error("credit count above UPLINK_CREDITS");

endmodule

`default_nettype wire

// ==== tb/agg_checker.sv ====
// scoreboard for the aggregator uplink, fed expected beats and drops by the testbench
// compares tagged beats per port, frame atomicity, the credit bound and the drop counters
`default_nettype none

module agg_checker #(
    parameter int ETHCOUNT       = 4,
    parameter int UPLINK_CREDITS = 4
) (
    input wire                                             clk20_g,
    input wire                                             rst_n_i,
    input wire                                             up_valid_i,
    input wire ethagg_pkg::up_beat_t                       up_beat_i,
    input wire                                             up_credit_i,
    input wire [ETHCOUNT-1:0][ethagg_pkg::DROP_CNT_W-1:0] drop_count_i
);
    import ethagg_pkg::*;

    int                errors      = 0;
    // beats on the uplink not yet paid back by a credit
    int                outstanding = 0;
    // expected {data, last} per port, in arrival order
    logic [BYTE_W:0]   exp_q [ETHCOUNT][$];
    int                exp_drops [ETHCOUNT] = '{default: 0};
    logic              in_frame   = 1'b0;
    logic [PORT_W-1:0] frame_port = '0;

    function automatic void push_beat(input int port, input logic [BYTE_W-1:0] data,
                                      input logic last);
        exp_q[port].push_back({data, last});
    endfunction

    function automatic void add_drop(input int port);
        exp_drops[port]++;
    endfunction

    function automatic int pending();
        int n;
        n = 0;
        for (int p = 0; p < ETHCOUNT; p++) begin
            n += exp_q[p].size();
        end
        return n;
    endfunction

    task automatic report_mismatch(input string name, input int exp_v, input int act_v);
        errors++;
        $display("** Error at time %0t: %s expected 0x%0h got 0x%0h", $time, name, exp_v, act_v);
    endtask

    task automatic check_drops();
        for (int p = 0; p < ETHCOUNT; p++) begin
            if (int'(drop_count_i[p]) != exp_drops[p]) begin
                report_mismatch($sformatf("drop_count_o[%0d]", p), exp_drops[p],
                                int'(drop_count_i[p]));
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // uplink monitor, sampled mid cycle
    // ------------------------------------------------------------------------
    always @(negedge clk20_g) begin
        logic [BYTE_W:0] exp_b;
        int              p;
        if (rst_n_i) begin
            outstanding = outstanding + int'(up_valid_i) - int'(up_credit_i);
            if (outstanding > UPLINK_CREDITS || outstanding < 0) begin
                report_mismatch("outstanding uplink beats", UPLINK_CREDITS, outstanding);
            end
            if (up_valid_i) begin
                p = int'(up_beat_i.port_idx);
                // another port broke into a frame
                if (in_frame && up_beat_i.port_idx != frame_port) begin
                    report_mismatch("up_beat_o.port_idx", frame_port, p);
                end
                if (exp_q[p].size() == 0) begin
                    errors++;
                    $display("uplink beat from port %0d at time %0t with no frame pending",
                             p, $time);
                end else begin
                    exp_b = exp_q[p].pop_front();
                    if (up_beat_i.data != exp_b[BYTE_W:1]) begin
                        report_mismatch("up_beat_o.data", exp_b[BYTE_W:1], up_beat_i.data);
                    end
                    if (up_beat_i.last != exp_b[0]) begin
                        report_mismatch("up_beat_o.last", exp_b[0], up_beat_i.last);
                    end
                end
                in_frame   = !up_beat_i.last;
                frame_port = up_beat_i.port_idx;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb/tb_eth_aggregator.sv ====
// testbench top for the Ethernet aggregator
// applies a table of frames per port and returns uplink credits after a set delay
`default_nettype none

module tb_eth_aggregator;
    import ethagg_pkg::*;

    localparam int NPORTS        = 4;
    localparam int FIFO_DEPTH    = 16;
    localparam int CREDITS       = 4;
    localparam int HALF_PERIOD   = 20;
    localparam int DRIVE_DLY     = 2;
    localparam int DRAIN_TIMEOUT = 2000;
    localparam int NUM_TESTS     = 13;
    // port code that sends two frames on every port at once
    localparam int ALL_PORTS     = NPORTS;
    localparam int NO_BAD        = -1;

    localparam port_status_t ST_UP   = '{1'b0, SPEED_1G, 1'b1};
    localparam port_status_t ST_DOWN = '{1'b0, SPEED_1G, 1'b0};
    localparam port_status_t ST_100M = '{1'b0, 2'b01, 1'b1};

    // one table row, keep is the expected outcome
    typedef struct packed {
        int           port;
        int           len;
        int           bad_pos;
        port_status_t st;
        int           credit_dly;
        logic         keep;
    } test_t;

    logic                              clk20_g;
    logic                              rst_n = 1'b0;
    logic [NPORTS-1:0]                 mac_valid;
    eth_beat_t                         mac_beat [NPORTS];
    port_status_t                      mac_status [NPORTS];
    logic                              up_credit = 1'b0;
    logic                              up_valid;
    up_beat_t                          up_beat;
    logic [NPORTS-1:0][DROP_CNT_W-1:0] drop_count;

    test_t tests [NUM_TESTS];
    int    seed       = 32'hb1928696;
    int    cyc        = 0;
    int    credit_dly = 1;
    // cycles at which the uplink frees a slot
    int    due_q [$];

    eth_aggregator #(
        .ETHCOUNT       (NPORTS),
        .FIFO_DEPTH     (FIFO_DEPTH),
        .UPLINK_CREDITS (CREDITS)
    ) dut0 (
        .clk20_g      (clk20_g),
        .rst_n_i      (rst_n),
        .mac_valid_i  (mac_valid),
        .mac_beat_i   (mac_beat),
        .mac_status_i (mac_status),
        .up_credit_i  (up_credit),
        .up_valid_o   (up_valid),
        .up_beat_o    (up_beat),
        .drop_count_o (drop_count)
    );

    agg_checker #(
        .ETHCOUNT       (NPORTS),
        .UPLINK_CREDITS (CREDITS)
    ) chk0 (
        .clk20_g      (clk20_g),
        .rst_n_i      (rst_n),
        .up_valid_i   (up_valid),
        .up_beat_i    (up_beat),
        .up_credit_i  (up_credit),
        .drop_count_i (drop_count)
    );

    initial begin
        clk20_g = 1'b0;
        forever #HALF_PERIOD clk20_g = ~clk20_g;
    end

    // ------------------------------------------------------------------------
    // uplink model, one credit per beat after credit_dly cycles
    // ------------------------------------------------------------------------
    always @(negedge clk20_g) begin
        if (up_valid) begin
            due_q.push_back(cyc + credit_dly);
        end
    end

    always @(posedge clk20_g) begin
        #DRIVE_DLY;
        cyc++;
        if (due_q.size() != 0 && due_q[0] <= cyc) begin
            void'(due_q.pop_front());
            up_credit = 1'b1;
        end else begin
            up_credit = 1'b0;
        end
    end

    // ------------------------------------------------------------------------
    // frame driver
    // ------------------------------------------------------------------------
    task automatic send_frame(input int port, input int len, input int bad_pos,
                              input port_status_t st, input logic keep);
        eth_beat_t b;
        for (int i = 0; i < len; i++) begin
            @(posedge clk20_g);
            #DRIVE_DLY;
            b.data           = BYTE_W'($random(seed));
            b.last           = (i == len - 1);
            b.bad            = (i == bad_pos);
            mac_status[port] = st;
            mac_beat[port]   = b;
            mac_valid[port]  = 1'b1;
            if (keep) begin
                chk0.push_beat(port, b.data, b.last);
            end
        end
        @(posedge clk20_g);
        #DRIVE_DLY;
        mac_valid[port]  = 1'b0;
        mac_status[port] = ST_UP;
        if (!keep) begin
            chk0.add_drop(port);
        end
    endtask

    // two frames back to back, order must survive the merge
    task automatic send_pair(input int port, input int len, input port_status_t st,
                             input logic keep);
        send_frame(port, len, NO_BAD, st, keep);
        send_frame(port, len, NO_BAD, st, keep);
    endtask

    task automatic wait_drained(output logic ok);
        int n;
        n = 0;
        while ((chk0.pending() != 0 || chk0.outstanding != 0) && n < DRAIN_TIMEOUT) begin
            @(posedge clk20_g);
            n++;
        end
        ok = (chk0.pending() == 0 && chk0.outstanding == 0);
    endtask

    task automatic load_table();
        // port, len, bad beat, status, credit delay, kept
        tests[0]  = '{0, 8, NO_BAD, ST_UP, 1, 1'b1};
        tests[1]  = '{1, 5, NO_BAD, ST_UP, 1, 1'b1};
        tests[2]  = '{2, 12, NO_BAD, ST_UP, 2, 1'b1};
        tests[3]  = '{3, 3, NO_BAD, ST_UP, 1, 1'b1};
        // bad flag mid frame and on the last beat
        tests[4]  = '{1, 9, 4, ST_UP, 1, 1'b0};
        tests[5]  = '{3, 6, 5, ST_UP, 1, 1'b0};
        // one byte more than the whole store
        tests[6]  = '{2, 17, NO_BAD, ST_UP, 1, 1'b0};
        tests[7]  = '{2, 4, NO_BAD, ST_UP, 1, 1'b1};
        tests[8]  = '{0, 7, NO_BAD, ST_DOWN, 1, 1'b0};
        tests[9]  = '{3, 7, NO_BAD, ST_100M, 1, 1'b0};
        tests[10] = '{ALL_PORTS, 6, NO_BAD, ST_UP, 1, 1'b1};
        // slow uplink
        tests[11] = '{1, 10, NO_BAD, ST_UP, 12, 1'b1};
        tests[12] = '{ALL_PORTS, 6, NO_BAD, ST_UP, 9, 1'b1};
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial begin
        test_t t;
        int    failed;
        int    ran;
        int    err_before;
        logic  drained;
        string what;
        failed    = 0;
        ran       = 0;
        mac_valid = '0;
        for (int p = 0; p < NPORTS; p++) begin
            mac_beat[p]   = '0;
            mac_status[p] = ST_UP;
        end
        load_table();
        repeat (4) @(posedge clk20_g);
        #DRIVE_DLY;
        rst_n = 1'b1;

        for (int n = 0; n < NUM_TESTS; n++) begin
            t          = tests[n];
            credit_dly = t.credit_dly;
            err_before = chk0.errors;
            ran++;
            if (t.port == ALL_PORTS) begin
                what = "all ports";
                fork
                    send_pair(0, t.len, t.st, t.keep);
                    send_pair(1, t.len, t.st, t.keep);
                    send_pair(2, t.len, t.st, t.keep);
                    send_pair(3, t.len, t.st, t.keep);
                join
            end else begin
                what = $sformatf("port %0d", t.port);
                send_frame(t.port, t.len, t.bad_pos, t.st, t.keep);
            end
            wait_drained(drained);
            if (!drained) begin
                $display("test %0d: uplink still busy after %0d cycles, frames or credits lost",
                         n, DRAIN_TIMEOUT);
                failed++;
                break;
            end
            chk0.check_drops();
            if (chk0.errors != err_before) begin
                failed++;
                $display("test %0d %s len %0d: FAIL", n, what, t.len);
            end else begin
                $display("test %0d %s len %0d: ok", n, what, t.len);
            end
        end

        $display("tests run %0d, failed %0d, checker errors %0d", ran, failed, chk0.errors);
        if (failed == 0 && chk0.errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
